// File: source/core_pkg.sv
// Shared definitions of the multichannel core
// Datapath, instruction store and register file sizes
// Operation codes and the instruction field layout
// Fetch and execute pipeline payloads
package core_pkg;

    localparam int data_width       = 32;
    localparam int instr_width      = 32;
    localparam int imm_width        = 16;
    localparam int imem_depth       = 64;
    localparam int pc_width         = $clog2(imem_depth);
    localparam int regs_per_channel = 16;
    localparam int reg_addr_width   = $clog2(regs_per_channel);
    localparam int max_channels     = 4;
    localparam int ch_width         = $clog2(max_channels);

    // Register file is addressed by channel then register number
    localparam int rf_addr_width    = ch_width + reg_addr_width;
    localparam int rf_depth         = max_channels * regs_per_channel;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_shl  = 4'd6,
        op_ldi  = 4'd7,
        op_ldch = 4'd8,
        op_out  = 4'd9,
        op_stop = 4'd10
    } opcode_t;

    // Field order from the most significant bit down
    typedef struct packed {
        opcode_t                   opcode;
        logic [reg_addr_width-1:0] dest;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
        logic [imm_width-1:0]      imm;
    } instr_fields_t;

    typedef struct packed {
        logic [instr_width-1:0] word;
        logic [ch_width-1:0]    channel;
    } fetch_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [ch_width-1:0]       channel;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     a;
        logic [data_width-1:0]     b;
        logic [data_width-1:0]     imm;
    } exec_t;

    // Operations that retire a register write
    function automatic logic writes_reg(opcode_t opcode);
        return opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_ldi, op_ldch};
    endfunction

endpackage

// File: source/pipe_stage.sv
// Single valid/ready pipeline register
// Payload type is a parameter, full throughput
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic full;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out_payload <= in_payload;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> $stable(out_payload));

endmodule

// File: source/instruction_store.sv
// Instruction memory of the core
// Host write port and a registered read port with enable
`timescale 1ns/1ps

module instruction_store
    import core_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   write_en,
    input  logic [pc_width-1:0]    write_addr,
    input  logic [instr_width-1:0] write_data,
    input  logic                   read_enable,
    input  logic [pc_width-1:0]    read_addr,
    output logic [instr_width-1:0] read_data
);

    logic [instr_width-1:0] mem [imem_depth];

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Output word holds while the fetch stage is full
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (read_enable) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

// File: source/register_file.sv
// Channelised register file
// One bank of registers per channel, two combinational reads, one write
`timescale 1ns/1ps

module register_file
    import core_pkg::*;
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic [rf_addr_width-1:0] read_addr_a,
    input  logic [rf_addr_width-1:0] read_addr_b,
    output logic [data_width-1:0]    read_data_a,
    output logic [data_width-1:0]    read_data_b,
    input  logic                     write_en,
    input  logic [rf_addr_width-1:0] write_addr,
    input  logic [data_width-1:0]    write_data
);

    logic [data_width-1:0] regs [rf_depth];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rf_depth; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // Reads see the value before a write on the same edge
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];

endmodule

// File: source/instruction_decoder.sv
// Instruction decoder
// Field split, channel-qualified operand reads, immediate sign extension
// Builds the execute payload
`timescale 1ns/1ps

module instruction_decoder
    import core_pkg::*;
(
    input  fetch_t                   fetch,
    output logic [rf_addr_width-1:0] reg_read_addr_a,
    output logic [rf_addr_width-1:0] reg_read_addr_b,
    input  logic [data_width-1:0]    reg_read_data_a,
    input  logic [data_width-1:0]    reg_read_data_b,
    output exec_t                    decoded
);

    instr_fields_t fields;

    assign fields = instr_fields_t'(fetch.word);

    // Each channel sees only its own register bank
    assign reg_read_addr_a = {fetch.channel, fields.src_a};
    assign reg_read_addr_b = {fetch.channel, fields.src_b};

    always_comb begin
        decoded.channel = fetch.channel;
        decoded.dest    = fields.dest;
        decoded.a       = reg_read_data_a;
        decoded.b       = reg_read_data_b;
        decoded.imm     = {{(data_width-imm_width){fields.imm[imm_width-1]}}, fields.imm};
        // Unused codes execute as NOP
        if (fields.opcode > op_stop) begin
            decoded.opcode = op_nop;
        end else begin
            decoded.opcode = fields.opcode;
        end
    end

endmodule

// File: source/exec_unit.sv
// Execute stage of the core
// Integer operations and register writeback
// Output stream for OUT, STOP detection, retire report to control
`timescale 1ns/1ps

module exec_unit
    import core_pkg::*;
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  exec_t                     op,
    output logic                      reg_write_en,
    output logic [rf_addr_width-1:0]  reg_write_addr,
    output logic [data_width-1:0]     reg_write_data,
    output logic                      retire_valid,
    output logic [reg_addr_width-1:0] retire_dest,
    output logic [ch_width-1:0]       retire_channel,
    output logic                      stop_seen,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [data_width-1:0]     out_data,
    output logic [ch_width-1:0]       out_channel
);

    logic [data_width-1:0] result;
    logic                  is_out;
    logic                  accept;

    always_comb begin
        case (op.opcode)
            op_add:  result = op.a + op.b;
            op_sub:  result = op.a - op.b;
            op_and:  result = op.a & op.b;
            op_or:   result = op.a | op.b;
            op_xor:  result = op.a ^ op.b;
            op_shl:  result = op.a << op.b[4:0];
            op_ldi:  result = op.imm;
            op_ldch: result = data_width'(op.channel);
            default: result = '0;
        endcase
    end

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    // OUT leaves the stage only together with an output beat
    assign is_out      = op.opcode == op_out;
    assign in_ready    = !is_out || out_ready;
    assign accept      = in_valid && in_ready;

    assign out_valid   = in_valid && is_out;
    assign out_data    = op.a;
    assign out_channel = op.channel;

    assign reg_write_en   = accept && writes_reg(op.opcode);
    assign reg_write_addr = {op.channel, op.dest};
    assign reg_write_data = result;

    assign retire_valid   = reg_write_en;
    assign retire_dest    = op.dest;
    assign retire_channel = op.channel;
    assign stop_seen      = accept && (op.opcode == op_stop);

    // A waiting beat keeps its value and channel through the whole pipeline stall
    assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_channel)));

endmodule

// File: source/core_control.sv
// Run control of the multichannel core
// Idle, running and draining FSM with channel loop and program counter
// Scoreboard of in-flight register writes for the issue interlock
// Done pulse at the end of a run
`timescale 1ns/1ps

module core_control
    import core_pkg::*;
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      run,
    input  logic [ch_width-1:0]       channels,
    input  logic                      stall,
    input  logic                      retire_valid,
    input  logic [reg_addr_width-1:0] retire_dest,
    input  logic [ch_width-1:0]       retire_channel,
    input  logic                      stop_seen,
    input  logic [instr_width-1:0]    instr,
    output logic [pc_width-1:0]       pc,
    output logic                      issue_valid,
    output logic [ch_width-1:0]       issue_channel,
    output logic                      busy,
    output logic                      done
);

    typedef enum logic [1:0] {st_idle, st_running, st_draining} state_t;

    state_t               state;
    logic                 primed;
    logic [pc_width-1:0]  pc_reg;
    logic [ch_width-1:0]  chan_last;
    logic [rf_depth-1:0]  pending;
    instr_fields_t        fields;
    logic                 hazard;
    logic                 take;
    logic                 last_ch;
    logic                 last_stop;

    function automatic logic reads_a(opcode_t opcode);
        return opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_out};
    endfunction

    function automatic logic reads_b(opcode_t opcode);
        return opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_shl};
    endfunction

    //////////////////////////////
    // Issue and interlock
    //////////////////////////////

    assign fields = instr_fields_t'(instr);

    // Destination is checked too, so a pair is never pending twice
    assign hazard = (reads_a(fields.opcode) && pending[{issue_channel, fields.src_a}])
                 || (reads_b(fields.opcode) && pending[{issue_channel, fields.src_b}])
                 || (writes_reg(fields.opcode) && pending[{issue_channel, fields.dest}]);

    // Store word is valid one cycle after entering the running state
    assign issue_valid = (state == st_running) && primed && !hazard;
    assign take        = issue_valid && !stall;
    assign last_ch     = issue_channel == chan_last;
    assign last_stop   = stop_seen && (retire_channel == chan_last);
    assign busy        = state != st_idle;

    // Read address runs one step ahead of the slot register
    always_comb begin
        pc = pc_reg;
        if (state == st_idle) begin
            pc = '0;
        end else if (take && last_ch) begin
            pc = pc_reg + 1'b1;
        end
    end

    //////////////////////////////
    // Sequencing
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            primed        <= 1'b0;
            pc_reg        <= '0;
            issue_channel <= '0;
            chan_last     <= '0;
            done          <= 1'b0;
        end else begin
            primed <= state == st_running;
            pc_reg <= pc;
            done   <= (state == st_draining) && last_stop;
            case (state)
                st_idle: begin
                    issue_channel <= '0;
                    if (run) begin
                        chan_last <= channels;
                        state     <= st_running;
                    end
                end
                st_running: begin
                    if (take) begin
                        issue_channel <= last_ch ? '0 : issue_channel + 1'b1;
                        if (last_ch && fields.opcode == op_stop) begin
                            state <= st_draining;
                        end
                    end
                end
                default: begin
                    if (last_stop) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (retire_valid) begin
                pending[{retire_channel, retire_dest}] <= 1'b0;
            end
            if (take && writes_reg(fields.opcode)) begin
                pending[{issue_channel, fields.dest}] <= 1'b1;
            end
        end
    end

    // An idle core has no slot to issue and no write left in the pipeline
    assert property (@(posedge clock) disable iff (!rst_n)
        (state == st_idle) |-> (!issue_valid && pending == '0));

    assert property (@(posedge clock) disable iff (!rst_n) done |=> !done);

endmodule

// File: source/proc_core.sv
// Top level of the multichannel processor core
// Control, instruction store, fetch and execute stages
// Decoder, register file and execute unit
`timescale 1ns/1ps

module proc_core
    import core_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   load_valid,
    output logic                   load_ready,
    input  logic [pc_width-1:0]    load_addr,
    input  logic [instr_width-1:0] load_data,
    input  logic                   run,
    input  logic [ch_width-1:0]    channels,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [data_width-1:0]  out_data,
    output logic [ch_width-1:0]    out_channel,
    output logic                   done
);

    logic [pc_width-1:0]       pc;
    logic                      issue_valid;
    logic [ch_width-1:0]       issue_channel;
    logic                      busy;
    logic                      fetch_in_ready;
    logic [instr_width-1:0]    instr_word;
    fetch_t                    fetch_in;
    fetch_t                    fetch_out;
    logic                      fetch_valid;
    logic                      exec_in_ready;
    exec_t                     decoded;
    exec_t                     exec_op;
    logic                      exec_valid;
    logic                      exec_ready;
    logic [rf_addr_width-1:0]  rd_addr_a;
    logic [rf_addr_width-1:0]  rd_addr_b;
    logic [data_width-1:0]     rd_data_a;
    logic [data_width-1:0]     rd_data_b;
    logic                      wr_en;
    logic [rf_addr_width-1:0]  wr_addr;
    logic [data_width-1:0]     wr_data;
    logic                      retire_valid;
    logic [reg_addr_width-1:0] retire_dest;
    logic [ch_width-1:0]       retire_channel;
    logic                      stop_seen;

    assign load_ready = !busy;
    assign fetch_in   = '{word: instr_word, channel: issue_channel};

    core_control control_inst (
        .clock(clock), .rst_n(rst_n), .run(run), .channels(channels),
        .stall(!fetch_in_ready), .retire_valid(retire_valid), .retire_dest(retire_dest),
        .retire_channel(retire_channel), .stop_seen(stop_seen), .instr(instr_word),
        .pc(pc), .issue_valid(issue_valid), .issue_channel(issue_channel),
        .busy(busy), .done(done)
    );

    instruction_store store_inst (
        .clock(clock), .rst_n(rst_n), .write_en(load_valid && load_ready),
        .write_addr(load_addr), .write_data(load_data), .read_enable(fetch_in_ready),
        .read_addr(pc), .read_data(instr_word)
    );

    //////////////////////////////
    // Pipeline
    //////////////////////////////

    pipe_stage #(.payload_t(fetch_t)) fetch_stage_inst (
        .clock(clock), .rst_n(rst_n), .in_valid(issue_valid), .in_ready(fetch_in_ready),
        .in_payload(fetch_in), .out_valid(fetch_valid), .out_ready(exec_in_ready),
        .out_payload(fetch_out)
    );

    instruction_decoder decoder_inst (
        .fetch(fetch_out), .reg_read_addr_a(rd_addr_a), .reg_read_addr_b(rd_addr_b),
        .reg_read_data_a(rd_data_a), .reg_read_data_b(rd_data_b), .decoded(decoded)
    );

    register_file regfile_inst (
        .clock(clock), .rst_n(rst_n), .read_addr_a(rd_addr_a), .read_addr_b(rd_addr_b),
        .read_data_a(rd_data_a), .read_data_b(rd_data_b), .write_en(wr_en),
        .write_addr(wr_addr), .write_data(wr_data)
    );

    pipe_stage #(.payload_t(exec_t)) exec_stage_inst (
        .clock(clock), .rst_n(rst_n), .in_valid(fetch_valid), .in_ready(exec_in_ready),
        .in_payload(decoded), .out_valid(exec_valid), .out_ready(exec_ready),
        .out_payload(exec_op)
    );

    exec_unit exec_inst (
        .clock(clock), .rst_n(rst_n), .in_valid(exec_valid), .in_ready(exec_ready),
        .op(exec_op), .reg_write_en(wr_en), .reg_write_addr(wr_addr),
        .reg_write_data(wr_data), .retire_valid(retire_valid), .retire_dest(retire_dest),
        .retire_channel(retire_channel), .stop_seen(stop_seen), .out_valid(out_valid),
        .out_ready(out_ready), .out_data(out_data), .out_channel(out_channel)
    );

endmodule

// File: verif/proc_core_tb.sv
// Testbench of the multichannel processor core
// Clock, reset, stimulus and expected beats from the input file
// LFSR back-pressure on the output stream, checks and watchdog
`timescale 1ns/1ps

module proc_core_tb;
    import core_pkg::*;

    localparam int max_lines = 256;

    logic                   clock;
    logic                   rst_n;
    logic                   load_valid;
    logic                   load_ready;
    logic [pc_width-1:0]    load_addr;
    logic [instr_width-1:0] load_data;
    logic                   run;
    logic [ch_width-1:0]    channels;
    logic                   out_valid;
    logic                   out_ready;
    logic [data_width-1:0]  out_data;
    logic [ch_width-1:0]    out_channel;
    logic                   done;

    logic [7:0]  cmd_kind [max_lines];
    logic [31:0] cmd_a [max_lines];
    logic [31:0] cmd_b [max_lines];
    int          n_cmds;
    int          n_lines;
    logic        backpressure;
    logic [15:0] lfsr_state;

    proc_core proc_core_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic fail_run();
        $display("Errors found");
        $fatal(1);
    endtask

    // Drive after the rising edge, sample at the falling edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
        if (backpressure) begin
            lfsr_state = lfsr_step(lfsr_state);
            out_ready  = lfsr_state[0];
        end else begin
            out_ready = 1'b1;
        end
        @(negedge clock);
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
        @(posedge clock);
        #1;
        load_valid = 1'b1;
        load_addr  = addr[pc_width-1:0];
        load_data  = word;
        @(negedge clock);
        assert (load_ready) else begin
            $display("load_ready low while the core should be idle at %0t", $time);
            fail_run();
        end
        @(posedge clock);
        #1;
        load_valid = 1'b0;
    endtask

    task automatic start_run(input logic [31:0] count);
        @(posedge clock);
        #1;
        run      = 1'b1;
        channels = ch_width'(count - 1);
        @(posedge clock);
        #1;
        run = 1'b0;
        @(negedge clock);
        assert (!load_ready) else begin
            $display("load_ready still high after a run was started at %0t", $time);
            fail_run();
        end
    endtask

    task automatic expect_beat(input logic [31:0] ch, input logic [31:0] value);
        do begin
            next_cycle();
            assert (!load_ready && !done) else begin
                $display("Run ended before an expected output beat at %0t", $time);
                fail_run();
            end
        end while (!(out_valid && out_ready));
        assert (out_channel == ch[ch_width-1:0]) else begin
            $display("MISMATCH time=%0t out_channel expected=%0d got=%0d",
                     $time, ch, out_channel);
            fail_run();
        end
        assert (out_data == value) else begin
            $display("MISMATCH time=%0t out_data expected=%h got=%h", $time, value, out_data);
            fail_run();
        end
    endtask

    // done must follow the last beat once, with no further output
    task automatic finish_run();
        do begin
            next_cycle();
            assert (!(out_valid && out_ready)) else begin
                $display("Unexpected extra output beat at %0t", $time);
                fail_run();
            end
            assert (done || !load_ready) else begin
                $display("load_ready high before done at %0t", $time);
                fail_run();
            end
        end while (!done);
        next_cycle();
        assert (!done && load_ready) else begin
            $display("done longer than one cycle or core not idle at %0t", $time);
            fail_run();
        end
    endtask

    initial begin
        int         fd;
        int         code;
        logic [7:0] kind;
        string      skipped;
        int         i;

        rst_n        = 1'b0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        run          = 1'b0;
        channels     = '0;
        out_ready    = 1'b1;
        backpressure = 1'b0;
        lfsr_state   = 16'd3;
        n_cmds       = 0;
        n_lines      = 0;

        fd = $fopen("verif/program_input.txt", "r");
        assert (fd != 0) else begin
            $display("Cannot open the stimulus file");
            fail_run();
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            n_lines++;
            if (kind == "#") begin
                code = $fgets(skipped, fd);
            end else begin
                cmd_kind[n_cmds] = kind;
                if (kind == "L" || kind == "E") begin
                    code = $fscanf(fd, "%h %h", cmd_a[n_cmds], cmd_b[n_cmds]);
                end else begin
                    code = $fscanf(fd, "%h", cmd_a[n_cmds]);
                end
                assert (code == ((kind == "L" || kind == "E") ? 2 : 1)) else begin
                    $display("Stimulus file line %0d could not be read", n_lines);
                    fail_run();
                end
                n_cmds++;
            end
        end
        $fclose(fd);

        fork
            begin
                repeat (200 * n_lines) @(posedge clock);
                $display("Watchdog expired before the test sequence finished");
                fail_run();
            end
        join_none

        repeat (16) @(posedge clock);
        #1;
        rst_n = 1'b1;

        i = 0;
        while (i < n_cmds) begin
            case (cmd_kind[i])
                "L": load_word(cmd_a[i], cmd_b[i]);
                "B": backpressure = cmd_a[i][0];
                "R": begin
                    start_run(cmd_a[i]);
                    while (i + 1 < n_cmds && cmd_kind[i+1] == "E") begin
                        i++;
                        expect_beat(cmd_a[i], cmd_b[i]);
                    end
                    finish_run();
                end
                default: begin
                    $display("Unknown command in the stimulus file");
                    fail_run();
                end
            endcase
            i++;
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: verif/program_input.txt
# L addr word | R channel count | E channel value | B back-pressure 0 or 1
# Words are opcode, dest, src a, src b, 16-bit immediate, all hex
B 0
L 00 71000064
L 01 7200FFFD
L 02 13120000
L 03 90300000
L 04 24120000
L 05 90400000
L 06 35120000
L 07 90500000
L 08 46120000
L 09 90600000
L 0a 57120000
L 0b 90700000
L 0c 78000005
L 0d 69180000
L 0e 90900000
L 0f A0000000
R 1
E 0 00000061
E 0 00000067
E 0 00000064
E 0 FFFFFFFD
E 0 FFFFFF99
E 0 00000C80
# Four channels, LDCH based values under back-pressure
B 1
L 00 81000000
L 01 72000010
L 02 63120000
L 03 14310000
L 04 90400000
L 05 90100000
L 06 A0000000
R 4
E 0 00000000
E 1 00010001
E 2 00020002
E 3 00030003
E 0 00000000
E 1 00000001
E 2 00000002
E 3 00000003
# Registers left by both earlier runs, same program with and without back-pressure
L 00 1A940000
L 01 90A00000
L 02 A0000000
B 0
R 4
E 0 00000C80
E 1 00010001
E 2 00020002
E 3 00030003
B 1
R 4
E 0 00000C80
E 1 00010001
E 2 00020002
E 3 00030003

// File: proc_core.f
source/core_pkg.sv
source/pipe_stage.sv
source/instruction_store.sv
source/register_file.sv
source/instruction_decoder.sv
source/exec_unit.sv
source/core_control.sv
source/proc_core.sv
verif/proc_core_tb.sv

// File: Makefile
# Verilator build and run of the processor core testbench

VERILATOR ?= verilator
TOP       ?= proc_core_tb
FILELIST  ?= proc_core.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log reports no errors"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^No errors$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
